// ==== include/csr_defines.svh ====
// Machine-mode CSR block constants
// Register width, PMP sizing, CSR address map, identity values
// and the write masks shared by the RTL and the testbench
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

`define CSR_XLEN        32
`define CSR_PMP_ENTRIES 4
`define CSR_PA_BITS     34

// Machine CSR address map
`define CSR_ADR_MVENDORID     12'hF11
`define CSR_ADR_MARCHID       12'hF12
`define CSR_ADR_MIMPID        12'hF13
`define CSR_ADR_MHARTID       12'hF14
`define CSR_ADR_MISA          12'h301
`define CSR_ADR_MEDELEG       12'h302
`define CSR_ADR_MIDELEG       12'h303
`define CSR_ADR_MTVEC         12'h305
`define CSR_ADR_MCOUNTINHIBIT 12'h320
`define CSR_ADR_MSCRATCH      12'h340
`define CSR_ADR_MEPC          12'h341
`define CSR_ADR_MCAUSE        12'h342
`define CSR_ADR_MTVAL         12'h343
`define CSR_ADR_PMPCFG0       12'h3A0
`define CSR_ADR_PMPADDR0      12'h3B0

// RV32 with I, M and C
`define CSR_MISA_VALUE 32'h4000_1104
`define CSR_VENDOR_ID  32'h0000_0A5C
`define CSR_ARCH_ID    32'h0000_0017
`define CSR_IMP_ID     32'h0000_0100

`define CSR_CAUSE_ILLEGAL 5'd2
`define CSR_MTVEC_MASK    32'hFFFF_FFFD
`define CSR_MCAUSE_MASK   32'h8000_000F

`endif

// ==== list.f ====
+incdir+include
verilog/csrPkg.sv
verilog/csrCommand.sv
verilog/csrMachineRegs.sv
verilog/csrTrapUnit.sv
verilog/csrSubsystem.sv
verification/tbClockGen.sv
verification/csrTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the CSR subsystem testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module csrTb -o csrSim

# The log decides the result, so a failing run must not stop the script here
./obj_dir/csrSim > sim.log 2>&1 || true
cat sim.log

grep -q "Regression passed" sim.log

// ==== verification/csrTb.sv ====
// CSR subsystem testbench
// Reads command and trap cases with expected results from a data file,
// drives the DUT and checks each response, trap flag and redirect target
`timescale 1ns/100ps
`default_nettype none

`include "csr_defines.svh"

module csrTb;

  import csrPkg::*;

  localparam int TimeoutCycles = 20;

  logic     clk;
  logic     rstN;
  logic     cmdValid;
  csrCmdT   cmd;
  logic     extTrapValid;
  trapInfoT extTrap;
  logic     rspValid;
  csrRspT   rsp;
  logic     trapTaken;
  xlenT     trapTarget;

  tbClockGen i_clkGen (
    .clk  (clk),
    .rstN (rstN)
  );

  csrSubsystem i_dut (
    .clk          (clk),
    .rstN         (rstN),
    .cmdValid     (cmdValid),
    .cmd          (cmd),
    .extTrapValid (extTrapValid),
    .extTrap      (extTrap),
    .rspValid     (rspValid),
    .rsp          (rsp),
    .trapTaken    (trapTaken),
    .trapTarget   (trapTarget)
  );

  ////////////////////////////////////////////////////////////
  // Checking and waiting
  ////////////////////////////////////////////////////////////
  task automatic checkValue(input logic [`CSR_XLEN-1:0] actual,
                            input logic [`CSR_XLEN-1:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Regression failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic waitForReset();
    int cycles;
    cycles = 0;
    while (!rstN) begin
      @(posedge clk);
      cycles++;
      if (cycles > 4 * TimeoutCycles) begin
        $display("Reset was never released");
        $display("Regression failed");
        $fatal(1, "Reset timeout");
      end
    end
  endtask

  // Outputs are sampled on the falling edge, where they are settled
  task automatic waitForResult(input int caseNum);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!(rspValid || trapTaken)) begin
      cycles++;
      if (cycles >= TimeoutCycles) begin
        $display("Timeout waiting for a response or trap in case %0d", caseNum);
        $display("Regression failed");
        $fatal(1, "Response timeout");
      end
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus, one-cycle strobes driven 1 ns after the edge
  ////////////////////////////////////////////////////////////
  task automatic sendCommand(input logic [1:0] op, input logic [11:0] adr,
                             input logic [`CSR_XLEN-1:0] operand,
                             input logic [`CSR_XLEN-1:0] pc);
    @(posedge clk);
    #1;
    cmdValid    = 1'b1;
    cmd.op      = csrOpT'(op);
    cmd.adr     = adr;
    cmd.operand = operand;
    cmd.pc      = pc;
    @(posedge clk);
    #1;
    cmdValid = 1'b0;
  endtask

  task automatic sendTrap(input logic [4:0] cause, input logic [`CSR_XLEN-1:0] epc,
                          input logic [`CSR_XLEN-1:0] tval);
    @(posedge clk);
    #1;
    extTrapValid  = 1'b1;
    extTrap.cause = cause;
    extTrap.epc   = epc;
    extTrap.tval  = tval;
    @(posedge clk);
    #1;
    extTrapValid = 1'b0;
  endtask

  initial begin
    int          fd;
    int          fields;
    int          caseCount;
    int          gap;
    string       line;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    logic [31:0] expRdata;
    logic [31:0] expIllegal;
    logic [31:0] expTrap;
    logic [31:0] expTarget;

    cmdValid     = 1'b0;
    cmd          = '0;
    extTrapValid = 1'b0;
    extTrap      = '0;
    caseCount    = 0;
    void'($urandom(32'h11ba));

    fd = $fopen("verification/csr_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file");
      $display("Regression failed");
      $fatal(1, "Missing case file");
    end

    waitForReset();

    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h %h",
                       f1, f2, f3, f4, expRdata, expIllegal, expTrap, expTarget);
      if (fields != 8) begin
        $display("Malformed case line: %s", line);
        $display("Regression failed");
        $fatal(1, "Bad case file");
      end
      caseCount++;

      if (line.getc(0) == "C") begin
        sendCommand(f1[1:0], f2[11:0], f3, f4);
        waitForResult(caseCount);
        checkValue(xlenT'(rspValid), 32'd1, $sformatf("case %0d response valid", caseCount));
        checkValue(rsp.rdata, expRdata, $sformatf("case %0d rdata", caseCount));
        checkValue(xlenT'(rsp.illegal), expIllegal, $sformatf("case %0d illegal", caseCount));
        checkValue(xlenT'(trapTaken), expTrap, $sformatf("case %0d trap taken", caseCount));
        if (expTrap[0]) begin
          checkValue(trapTarget, expTarget, $sformatf("case %0d trap target", caseCount));
        end
      end else if (line.getc(0) == "T") begin
        sendTrap(f1[4:0], f2, f3);
        waitForResult(caseCount);
        checkValue(xlenT'(trapTaken), 32'd1, $sformatf("case %0d trap taken", caseCount));
        checkValue(xlenT'(rspValid), 32'd0, $sformatf("case %0d no response", caseCount));
        checkValue(trapTarget, expTarget, $sformatf("case %0d trap target", caseCount));
      end else begin
        $display("Unknown case kind in line: %s", line);
        $display("Regression failed");
        $fatal(1, "Bad case kind");
      end

      // Random idle gap between cases
      gap = int'($urandom() % 4);
      repeat (gap) @(posedge clk);
    end
    $fclose(fd);

    if (caseCount == 0) begin
      $display("The case file held no cases");
      $display("Regression failed");
      $fatal(1, "No cases");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verification/csr_cases.txt ====
# kind f1 f2 f3 f4 rdata illegal trap target (all hex)
# C: f1=op(0 rd,1 wr,2 set,3 clr) f2=adr f3=operand f4=pc; T: f1=cause f2=epc f3=tval f4=0
C 1 305 80000102 00001000 00000000 0 0 00000000
C 0 F11 00000000 00001004 00000A5C 0 0 00000000
C 0 F12 00000000 00001008 00000017 0 0 00000000
C 0 F13 00000000 0000100C 00000100 0 0 00000000
C 0 F14 00000000 00001010 00000000 0 0 00000000
C 0 301 00000000 00001014 40001104 0 0 00000000
C 1 F11 DEADBEEF 00001020 00000000 1 1 80000100
C 0 341 00000000 00001024 00001020 0 0 00000000
C 1 340 12345678 00001100 00000000 0 0 00000000
C 2 340 0000F000 00001104 12345678 0 0 00000000
C 3 340 00000678 00001108 1234F678 0 0 00000000
C 2 340 00000000 0000110C 1234F000 0 0 00000000
C 1 305 80000203 00001200 80000100 0 0 00000000
C 0 305 00000000 00001204 80000201 0 0 00000000
T 17 00002000 ABCD0000 0 00000000 0 1 8000021C
C 0 341 00000000 00001208 00002000 0 0 00000000
C 0 342 00000000 0000120C 80000007 0 0 00000000
C 0 343 00000000 00001210 ABCD0000 0 0 00000000
T 05 00003000 00001111 0 00000000 0 1 80000200
C 0 302 00000000 00004000 00000000 1 1 80000200
C 0 341 00000000 00004004 00004000 0 0 00000000
C 0 342 00000000 00004008 00000002 0 0 00000000
C 1 3B1 00AA5500 00004100 00000000 0 0 00000000
C 1 3B2 00BB6600 00004104 00000000 0 0 00000000
C 1 3A0 00880000 00004108 00000000 0 0 00000000
C 1 3B1 11111111 0000410C 00AA5500 0 0 00000000
C 1 3B2 22222222 00004110 00BB6600 0 0 00000000
C 0 3B1 00000000 00004114 00AA5500 0 0 00000000
C 0 3B2 00000000 00004118 00BB6600 0 0 00000000
C 1 3B0 33333333 0000411C 00000000 0 0 00000000
C 0 3B0 00000000 00004120 33333333 0 0 00000000
C 0 7C0 00000000 00005000 00000000 1 1 80000200

// ==== verification/tbClockGen.sv ====
// Testbench clock and reset generator
// 8 ns clock, active-low reset held for the first 10 cycles
`timescale 1ns/100ps
`default_nettype none

module tbClockGen (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Release just after the tenth rising edge
  initial begin
    rstN = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verilog/csrCommand.sv ====
// CSR command input stage
// Registers an incoming CSR instruction and decodes whether it
// attempts a write, before any legality or lock checks
`timescale 1ns/100ps
`default_nettype none

module csrCommand (
  input  logic            clk,
  input  logic            rstN,
  input  logic            cmdValid,
  input  csrPkg::csrCmdT  cmd,
  output logic            exValid,
  output csrPkg::csrCmdT  exCmd,
  output logic            exWriteAttempt
);

  import csrPkg::*;

  logic writeAttempt;

  // Set and clear with a zero operand only read the register
  always_comb begin
    writeAttempt = 1'b0;
    case (cmd.op)
      opWrite: writeAttempt = 1'b1;
      opSet,
      opClear: writeAttempt = (cmd.operand != '0);
      default: writeAttempt = 1'b0;
    endcase
  end

  // Control bits
  always_ff @(posedge clk) begin
    if (!rstN) begin
      exValid        <= 1'b0;
      exWriteAttempt <= 1'b0;
    end else begin
      exValid        <= cmdValid;
      exWriteAttempt <= cmdValid & writeAttempt;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (cmdValid) begin
      exCmd <= cmd;
    end
  end

  // A write attempt only ever comes with a live command
  aWriteNeedsValid : assert property (
    @(posedge clk) disable iff (!rstN) exWriteAttempt |-> exValid
  );

endmodule

`default_nettype wire

// ==== verilog/csrMachineRegs.sv ====
// Machine CSR register file
// Holds the machine CSRs and PMP entries, returns the old value,
// computes write, set and clear results, applies the PMP lock
// rules, flags illegal accesses and captures trap records
`timescale 1ns/100ps
`default_nettype none

`include "csr_defines.svh"

module csrMachineRegs (
  input  logic              clk,
  input  logic              rstN,
  input  logic              exValid,
  input  csrPkg::csrCmdT    exCmd,
  input  logic              exWriteAttempt,
  input  logic              mTrap,
  input  csrPkg::trapInfoT  mTrapInfo,
  output logic              rdValid,
  output csrPkg::csrRspT    rdRsp,
  output csrPkg::xlenT      rdPc,
  output csrPkg::xlenT      mtvec
);

  import csrPkg::*;

  localparam int NumPmp = `CSR_PMP_ENTRIES;

  csrAdrT adr;
  xlenT   readVal;
  xlenT   wrVal;
  xlenT   trapCause;
  logic   illegalAdr;
  logic   readOnlyAdr;
  logic   illegal;
  logic   commit;
  logic   pmpCfgHit;

  xlenT   mscratch;
  xlenT   mepc;
  xlenT   mcause;
  xlenT   mtval;
  xlenT   mcountinhibit;

  pmpCfgT [NumPmp-1:0]                    pmpCfg;
  logic   [NumPmp-1:0][`CSR_PA_BITS-3:0]  pmpAddr;
  logic   [NumPmp-1:0]                    pmpAddrHit;
  logic   [NumPmp-1:0]                    addrLocked;
  logic   [NumPmp-1:0]                    cfgLocked;
  logic   [NumPmp-1:0]                    pmpAddrWe;
  logic   [NumPmp-1:0]                    pmpCfgWe;

  assign adr         = exCmd.adr;
  assign pmpCfgHit   = (adr == `CSR_ADR_PMPCFG0);
  assign readOnlyAdr = adr inside {`CSR_ADR_MVENDORID, `CSR_ADR_MARCHID,
                                   `CSR_ADR_MIMPID, `CSR_ADR_MHARTID};
  assign illegal     = illegalAdr | (exWriteAttempt & readOnlyAdr);
  assign commit      = exWriteAttempt & ~illegal;

  ////////////////////////////////////////////////////////////
  // PMP decode and lock rules
  ////////////////////////////////////////////////////////////
  for (genvar i = 0; i < NumPmp; i++) begin : gPmp
    assign cfgLocked[i]  = pmpCfg[i][7];
    assign pmpAddrHit[i] = (adr == csrAdrT'(`CSR_ADR_PMPADDR0 + i));
    // A locked TOR entry above also protects this address
    if (i == NumPmp - 1) begin : gLast
      assign addrLocked[i] = pmpCfg[i][7];
    end else begin : gInner
      assign addrLocked[i] = pmpCfg[i][7] |
                             (pmpCfg[i+1][7] & (pmpCfg[i+1][4:3] == 2'b01));
    end
    assign pmpAddrWe[i] = commit & pmpAddrHit[i] & ~addrLocked[i];
    assign pmpCfgWe[i]  = commit & pmpCfgHit & ~cfgLocked[i];

    aLockedAddrHolds : assert property (
      @(posedge clk) disable iff (!rstN) addrLocked[i] |=> $stable(pmpAddr[i])
    );
  end

  ////////////////////////////////////////////////////////////
  // Read mux and illegal detection
  ////////////////////////////////////////////////////////////
  always_comb begin
    readVal    = '0;
    illegalAdr = 1'b0;
    if (|pmpAddrHit) begin
      for (int i = 0; i < NumPmp; i++) begin
        if (pmpAddrHit[i]) begin
          readVal = xlenT'(pmpAddr[i]);
        end
      end
    end else begin
      case (adr)
        `CSR_ADR_MVENDORID:     readVal = `CSR_VENDOR_ID;
        `CSR_ADR_MARCHID:       readVal = `CSR_ARCH_ID;
        `CSR_ADR_MIMPID:        readVal = `CSR_IMP_ID;
        `CSR_ADR_MHARTID:       readVal = '0;
        `CSR_ADR_MISA:          readVal = `CSR_MISA_VALUE;
        `CSR_ADR_MTVEC:         readVal = mtvec;
        `CSR_ADR_MCOUNTINHIBIT: readVal = mcountinhibit;
        `CSR_ADR_MSCRATCH:      readVal = mscratch;
        `CSR_ADR_MEPC:          readVal = mepc;
        `CSR_ADR_MCAUSE:        readVal = mcause;
        `CSR_ADR_MTVAL:         readVal = mtval;
        // Bytes packed low to high
        `CSR_ADR_PMPCFG0:       readVal = xlenT'(pmpCfg);
        // No delegation without supervisor mode
        `CSR_ADR_MEDELEG,
        `CSR_ADR_MIDELEG:       illegalAdr = 1'b1;
        default:                illegalAdr = 1'b1;
      endcase
    end
  end

  // Read-modify-write value
  always_comb begin
    case (exCmd.op)
      opWrite: wrVal = exCmd.operand;
      opSet:   wrVal = readVal | exCmd.operand;
      opClear: wrVal = readVal & ~exCmd.operand;
      default: wrVal = readVal;
    endcase
  end

  assign trapCause = {mTrapInfo.cause[4], {(`CSR_XLEN-5){1'b0}}, mTrapInfo.cause[3:0]};

  ////////////////////////////////////////////////////////////
  // Register storage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      mtvec         <= '0;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcountinhibit <= '0;
      pmpCfg        <= '0;
      pmpAddr       <= '0;
    end else begin
      if (commit && adr == `CSR_ADR_MTVEC) mtvec <= wrVal & `CSR_MTVEC_MASK;
      if (commit && adr == `CSR_ADR_MSCRATCH) mscratch <= wrVal;
      if (commit && adr == `CSR_ADR_MCOUNTINHIBIT) mcountinhibit <= wrVal;
      // Trap capture wins over a CSR write to the same register
      if (mTrap) begin
        mepc   <= mTrapInfo.epc;
        mcause <= trapCause;
        mtval  <= mTrapInfo.tval;
      end else begin
        if (commit && adr == `CSR_ADR_MEPC) mepc <= wrVal;
        if (commit && adr == `CSR_ADR_MCAUSE) mcause <= wrVal & `CSR_MCAUSE_MASK;
        if (commit && adr == `CSR_ADR_MTVAL) mtval <= wrVal;
      end
      for (int i = 0; i < NumPmp; i++) begin
        if (pmpCfgWe[i]) pmpCfg[i] <= wrVal[8*i +: 8];
        if (pmpAddrWe[i]) pmpAddr[i] <= wrVal[`CSR_PA_BITS-3:0];
      end
    end
  end

  assign rdValid       = exValid;
  assign rdPc          = exCmd.pc;
  assign rdRsp.rdata   = readVal;
  assign rdRsp.illegal = illegal;

  // Illegal accesses leave state alone, apart from a trap already in flight
  aIllegalNoUpdate : assert property (
    @(posedge clk) disable iff (!rstN)
    (exValid && illegal && !mTrap) |=>
      $stable({mtvec, mscratch, mepc, mcause, mtval, mcountinhibit, pmpCfg, pmpAddr})
  );

endmodule

`default_nettype wire

// ==== verilog/csrPkg.sv ====
// CSR block types
// Data, address and cause vectors, the CSR operation code
// and the structs carried between the input, register and trap stages
`default_nettype none

`include "csr_defines.svh"

package csrPkg;

  ////////////////////////////////////////////////////////////
  // Plain vectors
  ////////////////////////////////////////////////////////////
  typedef logic [`CSR_XLEN-1:0] xlenT;
  typedef logic [11:0]          csrAdrT;
  typedef logic [7:0]           pmpCfgT;

  // Bit 4 flags an interrupt, bits 3:0 hold the code
  typedef logic [4:0]           causeT;

  // Zicsr operations, immediate forms arrive already decoded
  typedef enum logic [1:0] {
    opRead,
    opWrite,
    opSet,
    opClear
  } csrOpT;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    csrOpT  op;
    csrAdrT adr;
    xlenT   operand;
    xlenT   pc;
  } csrCmdT;

  typedef struct packed {
    xlenT  epc;
    causeT cause;
    xlenT  tval;
  } trapInfoT;

  typedef struct packed {
    xlenT rdata;
    logic illegal;
  } csrRspT;

endpackage

`default_nettype wire

// ==== verilog/csrSubsystem.sv ====
// Machine-mode CSR subsystem
// Command input stage, machine register file and trap stage
`timescale 1ns/100ps
`default_nettype none

module csrSubsystem (
  input  logic              clk,
  input  logic              rstN,
  input  logic              cmdValid,
  input  csrPkg::csrCmdT    cmd,
  input  logic              extTrapValid,
  input  csrPkg::trapInfoT  extTrap,
  output logic              rspValid,
  output csrPkg::csrRspT    rsp,
  output logic              trapTaken,
  output csrPkg::xlenT      trapTarget
);

  import csrPkg::*;

  logic     exValid;
  csrCmdT   exCmd;
  logic     exWriteAttempt;
  logic     rdValid;
  csrRspT   rdRsp;
  xlenT     rdPc;
  xlenT     mtvec;
  logic     mTrap;
  trapInfoT mTrapInfo;

  csrCommand i_command (
    .clk            (clk),
    .rstN           (rstN),
    .cmdValid       (cmdValid),
    .cmd            (cmd),
    .exValid        (exValid),
    .exCmd          (exCmd),
    .exWriteAttempt (exWriteAttempt)
  );

  csrMachineRegs i_regs (
    .clk            (clk),
    .rstN           (rstN),
    .exValid        (exValid),
    .exCmd          (exCmd),
    .exWriteAttempt (exWriteAttempt),
    .mTrap          (mTrap),
    .mTrapInfo      (mTrapInfo),
    .rdValid        (rdValid),
    .rdRsp          (rdRsp),
    .rdPc           (rdPc),
    .mtvec          (mtvec)
  );

  csrTrapUnit i_trap (
    .clk          (clk),
    .rstN         (rstN),
    .rdValid      (rdValid),
    .rdRsp        (rdRsp),
    .rdPc         (rdPc),
    .mtvec        (mtvec),
    .extTrapValid (extTrapValid),
    .extTrap      (extTrap),
    .rspValid     (rspValid),
    .rsp          (rsp),
    .trapTaken    (trapTaken),
    .trapTarget   (trapTarget),
    .mTrap        (mTrap),
    .mTrapInfo    (mTrapInfo)
  );

endmodule

`default_nettype wire

// ==== verilog/csrTrapUnit.sv ====
// CSR response and trap stage
// Registers the CSR response, raises a trap for an illegal access
// or an external trap, and forms the trap record and redirect
`timescale 1ns/100ps
`default_nettype none

`include "csr_defines.svh"

module csrTrapUnit (
  input  logic              clk,
  input  logic              rstN,
  input  logic              rdValid,
  input  csrPkg::csrRspT    rdRsp,
  input  csrPkg::xlenT      rdPc,
  input  csrPkg::xlenT      mtvec,
  input  logic              extTrapValid,
  input  csrPkg::trapInfoT  extTrap,
  output logic              rspValid,
  output csrPkg::csrRspT    rsp,
  output logic              trapTaken,
  output csrPkg::xlenT      trapTarget,
  output logic              mTrap,
  output csrPkg::trapInfoT  mTrapInfo
);

  import csrPkg::*;

  logic     illegalTrap;
  trapInfoT nextTrap;
  xlenT     tvecBase;

  assign illegalTrap = rdValid & rdRsp.illegal;

  // Illegal access outranks an external trap in the same cycle
  always_comb begin
    if (illegalTrap) begin
      nextTrap.epc   = rdPc;
      nextTrap.cause = `CSR_CAUSE_ILLEGAL;
      nextTrap.tval  = '0;
    end else begin
      nextTrap = extTrap;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      rspValid  <= 1'b0;
      trapTaken <= 1'b0;
    end else begin
      rspValid  <= rdValid;
      trapTaken <= illegalTrap | extTrapValid;
    end
  end

  always_ff @(posedge clk) begin
    rsp.rdata   <= rdRsp.illegal ? '0 : rdRsp.rdata;
    rsp.illegal <= rdRsp.illegal;
    mTrapInfo   <= nextTrap;
  end

  assign mTrap = trapTaken;

  ////////////////////////////////////////////////////////////
  // Redirect, vectored only for interrupts
  ////////////////////////////////////////////////////////////
  assign tvecBase   = {mtvec[`CSR_XLEN-1:2], 2'b00};
  assign trapTarget = (mtvec[0] && mTrapInfo.cause[4]) ?
                      tvecBase + xlenT'({mTrapInfo.cause[3:0], 2'b00}) : tvecBase;

  aTrapMatch : assert property (
    @(posedge clk) disable iff (!rstN) trapTaken == mTrap
  );

endmodule

`default_nettype wire
